// ==== include/l2tlb_macros.svh ====
`ifndef L2TLB_MACROS_SVH
`define L2TLB_MACROS_SVH

// ==================================================
// Geometry of the level-1 page L2 TLB slice
// ==================================================

// Ways and sets
`define L2TLB_WAYS    4
`define L2TLB_SETS    64
`define L2TLB_SET_W   6
`define L2TLB_WAY_W   2

// Tag and data word layout
`define L2TLB_WORD_W  24
`define L2TLB_FLAG_W  10

// Compare key is asid plus upper vpn1
`define L2TLB_KEY_W   13
`define L2TLB_KEY_LSB 10

`endif

// ==== hdl/l2tlb_pkg.sv ====
`include "l2tlb_macros.svh"

package l2tlb_pkg;

    // Maintenance commands
    typedef enum logic [1:0] {
        MAINT_NONE      = 2'd0,
        MAINT_FILL      = 2'd1,
        MAINT_FLUSH_SET = 2'd2,
        MAINT_FLUSH_ALL = 2'd3
    } maint_op_e;

    // Flag bit 0 is the valid flag
    typedef struct packed {
        logic                       spare;
        logic [8:0]                 asid;
        logic [3:0]                 vpn_hi;
        logic [`L2TLB_FLAG_W-1:0]   flags;
    } tlb_tag_t;

    typedef struct packed {
        maint_op_e                  op;
        logic [`L2TLB_WAY_W-1:0]    way;
        logic [`L2TLB_SET_W-1:0]    set;
        tlb_tag_t                   tag;
        logic [`L2TLB_WORD_W-1:0]   data;
    } maint_req_t;

    typedef struct packed {
        logic                       req;
        logic [`L2TLB_SET_W-1:0]    set;
        logic [`L2TLB_KEY_W-1:0]    key;
    } lookup_req_t;

    // Shared memory port
    typedef struct packed {
        logic [`L2TLB_SET_W-1:0]    set;
        logic [`L2TLB_WAYS-1:0]     wr_mask;
        tlb_tag_t                   tag;
        logic [`L2TLB_WORD_W-1:0]   data;
    } sram_req_t;

    typedef struct packed {
        tlb_tag_t                   tag;
        logic [`L2TLB_WORD_W-1:0]   data;
    } sram_way_t;

    // One full set row
    typedef struct packed {
        sram_way_t [`L2TLB_WAYS-1:0] way;
    } sram_rd_t;

    typedef struct packed {
        logic                       valid;
        logic [`L2TLB_WAYS-1:0]     hit;
        logic [`L2TLB_WAYS-1:0]     set_valid;
        logic [`L2TLB_WORD_W-1:0]   data;
        tlb_tag_t                   tag;
    } lookup_resp_t;

endpackage

// ==== hdl/l2tlb_way_sram.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_way_sram
    import l2tlb_pkg::*;
(
    input  logic      clk,
    input  sram_req_t i_req,
    input  logic      i_rd_en,
    output sram_rd_t  o_rd
);

    // ==================================================
    // Tag and data storage, no reset
    // ==================================================

    sram_way_t mem [`L2TLB_SETS][`L2TLB_WAYS];

    // Per-way write
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            if (i_req.wr_mask[w]) begin
                mem[i_req.set][w].tag  <= i_req.tag;
                mem[i_req.set][w].data <= i_req.data;
            end
        end
    end

    // Synchronous row read, output held when idle
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            for (int w = 0; w < `L2TLB_WAYS; w++) begin
                o_rd.way[w] <= mem[i_req.set][w];
            end
        end
    end

endmodule

// ==== hdl/l2tlb_port_arbiter.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_port_arbiter
    import l2tlb_pkg::*;
(
    input  lookup_req_t i_lookup,
    input  maint_req_t  i_maint,
    output sram_req_t   o_sram_req,
    output logic        o_rd_en,
    output logic        o_lookup_grant
);

    logic                   fill;
    logic                   lookup_win;
    logic [`L2TLB_WAYS-1:0] way_dec;

    // Only a fill touches the memory, flushes leave the port free
    assign fill       = (i_maint.op == MAINT_FILL);
    assign lookup_win = i_lookup.req && !fill;

    // Way number to one-hot write mask
    assign way_dec = {{(`L2TLB_WAYS-1){1'b0}}, 1'b1} << i_maint.way;

    always_comb begin
        o_sram_req.set     = fill ? i_maint.set : i_lookup.set;
        o_sram_req.wr_mask = fill ? way_dec : '0;
        o_sram_req.tag     = i_maint.tag;
        o_sram_req.data    = i_maint.data;
    end

    assign o_rd_en        = lookup_win;
    assign o_lookup_grant = lookup_win;

endmodule

// ==== hdl/l2tlb_valid_array.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_valid_array
    import l2tlb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  maint_req_t              i_maint,
    input  logic [`L2TLB_SET_W-1:0] i_rd_set,
    output logic [`L2TLB_WAYS-1:0]  o_rd_valid
);

    // ==================================================
    // Valid bits, one row of ways per set
    // ==================================================

    logic [`L2TLB_WAYS-1:0] valid_q [`L2TLB_SETS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < `L2TLB_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            case (i_maint.op)
                MAINT_FILL: begin
                    // Valid follows the flag of the new tag
                    valid_q[i_maint.set][i_maint.way] <= i_maint.tag.flags[0];
                end
                MAINT_FLUSH_SET: begin
                    valid_q[i_maint.set] <= '0;
                end
                MAINT_FLUSH_ALL: begin
                    for (int s = 0; s < `L2TLB_SETS; s++) begin
                        valid_q[s] <= '0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Combinational read, pre-update value in a maintenance cycle
    assign o_rd_valid = valid_q[i_rd_set];

endmodule

// ==== hdl/l2tlb_lookup.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_lookup
    import l2tlb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  lookup_req_t             i_lookup,
    input  logic                    i_grant,
    input  sram_rd_t                i_rd,
    input  logic [`L2TLB_WAYS-1:0]  i_set_valid,
    output logic [`L2TLB_SET_W-1:0] o_rd_set,
    output lookup_resp_t            o_resp
);

    logic                    pend_q;
    logic [`L2TLB_KEY_W-1:0] key_q;
    logic [`L2TLB_WAYS-1:0]  vrow_q;
    logic [`L2TLB_WAYS-1:0]  way_match;
    logic [`L2TLB_WAYS-1:0]  hit_sel;
    logic [`L2TLB_WORD_W-1:0] sel_data;
    tlb_tag_t                sel_tag;

    // Valid row is read with the same set the SRAM sees
    assign o_rd_set = i_lookup.set;

    // ==================================================
    // Request stage, aligned with the SRAM read
    // ==================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_q <= 1'b0;
            key_q  <= '0;
            vrow_q <= '0;
        end else begin
            pend_q <= i_grant;
            if (i_grant) begin
                key_q  <= i_lookup.key;
                vrow_q <= i_set_valid;
            end
        end
    end

    // ==================================================
    // Compare and lowest-way select
    // ==================================================

    always_comb begin
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            way_match[w] = vrow_q[w] &&
                (i_rd.way[w].tag[`L2TLB_KEY_LSB +: `L2TLB_KEY_W] == key_q);
        end
    end

    // Walk downward so the lowest hitting way is the last one taken
    always_comb begin
        hit_sel  = '0;
        sel_data = '0;
        sel_tag  = '0;
        for (int w = `L2TLB_WAYS - 1; w >= 0; w--) begin
            if (way_match[w]) begin
                hit_sel        = '0;
                hit_sel[w]     = 1'b1;
                sel_data       = i_rd.way[w].data;
                sel_tag        = i_rd.way[w].tag;
                sel_tag.flags[0] = vrow_q[w];
            end
        end
    end

    always_comb begin
        o_resp.valid     = pend_q;
        o_resp.hit       = hit_sel;
        o_resp.set_valid = vrow_q;
        o_resp.data      = sel_data;
        o_resp.tag       = sel_tag;
    end

endmodule

// ==== hdl/l2tlb_top.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_top
    import l2tlb_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  lookup_req_t  i_lookup,
    input  maint_req_t   i_maint,
    output lookup_resp_t o_resp
);

    sram_req_t               sram_req;
    sram_rd_t                sram_rd;
    logic                    rd_en;
    logic                    lookup_grant;
    logic [`L2TLB_SET_W-1:0] rd_set;
    logic [`L2TLB_WAYS-1:0]  set_valid;

    // ==================================================
    // Shared port arbitration
    // ==================================================

    l2tlb_port_arbiter arbiter_i (
        .i_lookup       (i_lookup),
        .i_maint        (i_maint),
        .o_sram_req     (sram_req),
        .o_rd_en        (rd_en),
        .o_lookup_grant (lookup_grant)
    );

    l2tlb_way_sram way_sram_i (
        .clk     (clk),
        .i_req   (sram_req),
        .i_rd_en (rd_en),
        .o_rd    (sram_rd)
    );

    // Maintenance peer, flushes bypass the arbiter
    l2tlb_valid_array valid_array_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_maint    (i_maint),
        .i_rd_set   (rd_set),
        .o_rd_valid (set_valid)
    );

    // Lookup peer
    l2tlb_lookup lookup_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_lookup    (i_lookup),
        .i_grant     (lookup_grant),
        .i_rd        (sram_rd),
        .i_set_valid (set_valid),
        .o_rd_set    (rd_set),
        .o_resp      (o_resp)
    );

endmodule

// ==== tb/l2tlb_assert.sv ====
`timescale 1ns/1ps

module l2tlb_assert
    import l2tlb_pkg::*;
(
    input logic         clk,
    input logic         rstn,
    input lookup_req_t  i_lookup,
    input maint_req_t   i_maint,
    input lookup_resp_t o_resp
);

    // ==================================================
    // Response shape
    // ==================================================

    hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> $onehot0(o_resp.hit))
        else $error("o_resp.hit has more than one way set");

    // A hit way must come from a valid entry
    hit_is_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> (o_resp.hit & ~o_resp.set_valid) == '0)
        else $error("o_resp.hit points at a way whose valid bit is clear");

    // ==================================================
    // Lookup timing against the fill collision
    // ==================================================

    granted_answered: assert property (@(posedge clk) disable iff (!rstn)
        (i_lookup.req && i_maint.op != MAINT_FILL) |=> o_resp.valid)
        else $error("granted lookup got no response in the next cycle");

    fill_drops_lookup: assert property (@(posedge clk) disable iff (!rstn)
        (i_lookup.req && i_maint.op == MAINT_FILL) |=> !o_resp.valid)
        else $error("lookup issued with a fill still got a response");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> !o_resp.valid)
        else $error("o_resp.valid high right after reset release");

endmodule

bind l2tlb_top l2tlb_assert assert_i (
    .clk      (clk),
    .rstn     (rstn),
    .i_lookup (i_lookup),
    .i_maint  (i_maint),
    .o_resp   (o_resp)
);

// ==== tb/l2tlb_tb.sv ====
`timescale 1ns/1ps

`include "l2tlb_macros.svh"

module l2tlb_tb
    import l2tlb_pkg::*;
;

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 4;
    localparam int rand_probes     = 16;
    // Upper bound on directed fills, flushes, probes and drain
    localparam int directed_cycles = 48;
    localparam int stim_cycles     = 2 * rand_probes + directed_cycles;

    localparam lookup_req_t no_lookup = '0;
    localparam maint_req_t  no_maint  = '0;

    logic         clk;
    logic         rstn;
    lookup_req_t  i_lookup;
    maint_req_t   i_maint;
    lookup_resp_t o_resp;

    integer       seed = 32'h300e9817;
    lookup_resp_t exp_next = '0;
    lookup_resp_t exp_q = '0;

    // Reference model of the slice
    tlb_tag_t                 model_tag   [`L2TLB_SETS][`L2TLB_WAYS];
    logic [`L2TLB_WORD_W-1:0] model_data  [`L2TLB_SETS][`L2TLB_WAYS];
    logic [`L2TLB_WAYS-1:0]   model_valid [`L2TLB_SETS];

    l2tlb_top l2tlb_top_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_lookup (i_lookup),
        .i_maint  (i_maint),
        .o_resp   (o_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Expected response lines up with the DUT output stage
    always @(posedge clk) begin
        exp_q <= exp_next;
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("ERROR at %0t: o_resp.%s expected 0x%0h, got 0x%0h",
                 $time, field, exp_val, act_val);
        stop_with_failure();
    endtask

    // ==================================================
    // Response checks
    // ==================================================

    check_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid == exp_q.valid)
        else report_mismatch("valid", 32'($sampled(exp_q.valid)), 32'($sampled(o_resp.valid)));

    check_hit: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> o_resp.hit == exp_q.hit)
        else report_mismatch("hit", 32'($sampled(exp_q.hit)), 32'($sampled(o_resp.hit)));

    check_set_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> o_resp.set_valid == exp_q.set_valid)
        else report_mismatch("set_valid", 32'($sampled(exp_q.set_valid)),
                             32'($sampled(o_resp.set_valid)));

    check_data: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> o_resp.data == exp_q.data)
        else report_mismatch("data", 32'($sampled(exp_q.data)), 32'($sampled(o_resp.data)));

    check_tag: assert property (@(posedge clk) disable iff (!rstn)
        o_resp.valid |-> o_resp.tag == exp_q.tag)
        else report_mismatch("tag", 32'($sampled(exp_q.tag)), 32'($sampled(o_resp.tag)));

    // ==================================================
    // Model and stimulus helpers
    // ==================================================

    function automatic lookup_resp_t expect_lookup(input lookup_req_t lk);
        lookup_resp_t resp;
        logic         found;
        resp           = '0;
        found          = 1'b0;
        resp.valid     = 1'b1;
        resp.set_valid = model_valid[lk.set];
        // Lowest matching valid way wins
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            if (!found && model_valid[lk.set][w] &&
                model_tag[lk.set][w][`L2TLB_KEY_LSB +: `L2TLB_KEY_W] == lk.key) begin
                found              = 1'b1;
                resp.hit[w]        = 1'b1;
                resp.data          = model_data[lk.set][w];
                resp.tag           = model_tag[lk.set][w];
                resp.tag.flags[0]  = model_valid[lk.set][w];
            end
        end
        return resp;
    endfunction

    task automatic apply_maint(input maint_req_t mt);
        case (mt.op)
            MAINT_FILL: begin
                model_tag[mt.set][mt.way]   = mt.tag;
                model_data[mt.set][mt.way]  = mt.data;
                model_valid[mt.set][mt.way] = mt.tag.flags[0];
            end
            MAINT_FLUSH_SET: model_valid[mt.set] = '0;
            MAINT_FLUSH_ALL: begin
                for (int s = 0; s < `L2TLB_SETS; s++) begin
                    model_valid[s] = '0;
                end
            end
            default: begin
            end
        endcase
    endtask

    function automatic lookup_req_t lookup_cmd(input logic [`L2TLB_SET_W-1:0] set,
                                               input logic [`L2TLB_KEY_W-1:0] key);
        lookup_req_t lk;
        lk.req = 1'b1;
        lk.set = set;
        lk.key = key;
        return lk;
    endfunction

    function automatic maint_req_t fill_cmd(input logic [`L2TLB_SET_W-1:0] set,
                                            input logic [`L2TLB_WAY_W-1:0] way,
                                            input logic [`L2TLB_KEY_W-1:0] key,
                                            input logic flag0);
        maint_req_t  mt;
        logic [31:0] r;
        r              = $random(seed);
        mt             = '0;
        mt.op          = MAINT_FILL;
        mt.way         = way;
        mt.set         = set;
        mt.tag.spare   = r[31];
        mt.tag.asid    = key[12:4];
        mt.tag.vpn_hi  = key[3:0];
        mt.tag.flags   = {r[30:22], flag0};
        mt.data        = r[23:0];
        return mt;
    endfunction

    function automatic maint_req_t flush_cmd(input maint_op_e op,
                                             input logic [`L2TLB_SET_W-1:0] set);
        maint_req_t mt;
        mt     = '0;
        mt.op  = op;
        mt.set = set;
        return mt;
    endfunction

    // One clock of stimulus with the expectation taken before the model update
    task automatic step(input lookup_req_t lk, input maint_req_t mt);
        lookup_resp_t resp;
        resp = '0;
        if (lk.req && mt.op != MAINT_FILL) begin
            resp = expect_lookup(lk);
        end
        exp_next = resp;
        apply_maint(mt);
        i_lookup = lk;
        i_maint  = mt;
        @(posedge clk);
        #1;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        logic [31:0]              rnd;
        logic [`L2TLB_SET_W-1:0]  set_a;
        logic [`L2TLB_SET_W-1:0]  set_b;
        logic [`L2TLB_KEY_W-1:0]  key_base;
        logic [`L2TLB_KEY_W-1:0]  key_a;
        logic [`L2TLB_KEY_W-1:0]  key_b;
        rstn     = 1'b0;
        i_lookup = no_lookup;
        i_maint  = no_maint;
        for (int s = 0; s < `L2TLB_SETS; s++) begin
            model_valid[s] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Empty slice after reset
        for (int i = 0; i < rand_probes; i++) begin
            rnd = $random(seed);
            step(lookup_cmd(rnd[5:0], rnd[18:6]), no_maint);
        end

        // Distinct keys in every way of one set
        rnd      = $random(seed);
        set_a    = rnd[5:0];
        set_b    = set_a + 6'd1;
        key_base = {rnd[20:10], 2'b00};
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            step(no_lookup, fill_cmd(set_a, 2'(w), key_base | 13'(w), 1'b1));
        end
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            step(lookup_cmd(set_a, key_base | 13'(w)), no_maint);
        end
        step(lookup_cmd(set_a, key_base ^ 13'h1000), no_maint);

        // Duplicate keys and fills with the valid flag clear
        rnd   = $random(seed);
        key_a = rnd[12:0];
        key_b = key_a ^ 13'h0001;
        step(no_lookup, fill_cmd(set_b, 2'd1, key_a, 1'b1));
        step(no_lookup, fill_cmd(set_b, 2'd3, key_a, 1'b1));
        step(lookup_cmd(set_b, key_a), no_maint);
        step(no_lookup, fill_cmd(set_b, 2'd0, key_a, 1'b0));
        step(lookup_cmd(set_b, key_a), no_maint);
        step(no_lookup, fill_cmd(set_b, 2'd2, key_b, 1'b0));
        step(lookup_cmd(set_b, key_b), no_maint);
        step(no_lookup, fill_cmd(set_b, 2'd1, key_a, 1'b0));
        step(lookup_cmd(set_b, key_a), no_maint);

        // Set flush then global flush
        step(no_lookup, flush_cmd(MAINT_FLUSH_SET, set_a));
        for (int w = 0; w < `L2TLB_WAYS; w++) begin
            step(lookup_cmd(set_a, key_base | 13'(w)), no_maint);
        end
        step(lookup_cmd(set_b, key_a), no_maint);
        // Set field points away from the populated set
        step(no_lookup, flush_cmd(MAINT_FLUSH_ALL, set_a));
        step(lookup_cmd(set_b, key_a), no_maint);
        for (int i = 0; i < rand_probes / 2; i++) begin
            rnd = $random(seed);
            step(lookup_cmd(rnd[5:0], rnd[18:6]), no_maint);
        end

        // Lookups colliding with maintenance and back to back lookups
        step(no_lookup, fill_cmd(set_a, 2'd0, key_base, 1'b1));
        step(lookup_cmd(set_a, key_base), fill_cmd(set_b, 2'd2, key_b, 1'b1));
        step(lookup_cmd(set_a, key_base), flush_cmd(MAINT_FLUSH_SET, set_a));
        step(lookup_cmd(set_a, key_base), no_maint);
        step(no_lookup, fill_cmd(set_a, 2'd0, key_base, 1'b1));
        step(lookup_cmd(set_b, key_b), flush_cmd(MAINT_FLUSH_SET, set_a));
        step(lookup_cmd(set_a, key_base), no_maint);
        step(lookup_cmd(set_b, key_b ^ 13'h1000), no_maint);
        step(lookup_cmd(set_b, key_b), flush_cmd(MAINT_FLUSH_ALL, set_a));
        step(lookup_cmd(set_b, key_b), no_maint);

        repeat (3) step(no_lookup, no_maint);

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #((reset_cycles + stim_cycles + 20) * clk_period);
        $display("Timeout, the test did not finish");
        stop_with_failure();
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/l2tlb_pkg.sv
hdl/l2tlb_way_sram.sv
hdl/l2tlb_port_arbiter.sv
hdl/l2tlb_valid_array.sv
hdl/l2tlb_lookup.sv
hdl/l2tlb_top.sv
tb/l2tlb_assert.sv
tb/l2tlb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the L2 TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sources.f \
    --top-module l2tlb_tb -Mdir "$OBJ" -o l2tlb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/l2tlb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
